// File: rv_core.f
+incdir+include
hdl/rv_pkg.sv
hdl/inst_mem.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/result_unit.sv
hdl/rv_core.sv
verif/tb_clock.sv
verif/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the core and its testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f rv_core.f --top-module rv_core_tb -o rv_core_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: verif/rv_core_tb.sv
/* testbench for rv_core: loads programs through the load port while in reset,
   predicts every retire with an instruction-level model and checks them in order */

`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_tb;

	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_imm    = 7'b0010011;
	localparam logic [6:0] opc_reg    = 7'b0110011;

	logic                           clk;
	logic                           reset     = 1'b1;
	logic                           stall     = 1'b0;
	logic                           prog_we   = 1'b0;
	logic [`RV_IMEM_ADDR_WIDTH-1:0] prog_addr = '0;
	logic [31:0]                    prog_data = '0;
	rv_pkg::retire_t                retire;
	logic                           halted;

	logic [31:0]     prog [0:`RV_IMEM_DEPTH-1]; // image loaded into the DUT, read by the model
	logic [31:0]     ref_regs [0:31];
	rv_pkg::retire_t exp_q [$];                 // expected retires, oldest first
	integer          seed = 32'h2698_616b;
	int              pc_idx = 0;                // next word written by emit_word
	int              mismatch_errors = 0;
	int              other_errors = 0;
	int              checked = 0;
	int              cycles = 0;
	int              budget = 50;               // cycle limit, grows with each program
	logic            checking = 1'b0;
	logic            stall_en = 1'b0;
	logic            stalled_last = 1'b0;
	logic            halted_last = 1'b0;

	tb_clock clock_i (.clk(clk));

	rv_core rv_core_i (
		.clk(clk), .reset(reset), .stall(stall), .prog_we(prog_we),
		.prog_addr(prog_addr), .prog_data(prog_data), .retire(retire), .halted(halted)
	);

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	                                      input logic [4:0] rs1, input logic [2:0] f3,
	                                      input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opc_reg};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
	                                      input logic [4:0] rs1, input logic [2:0] f3,
	                                      input logic [4:0] rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [19:0] imm,
	                                      input logic [4:0] rd);
		return {imm, rd, op};
	endfunction

	// offsets are byte offsets, bit 0 dropped by the format
	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
	                                      input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
	endfunction

	// one instruction of the ISA on prog and ref_regs
	function automatic rv_pkg::retire_t model_step(input logic [`RV_PC_WIDTH-1:0] pc,
	                                               output logic [`RV_PC_WIDTH-1:0] next_pc);
		rv_pkg::retire_t         r;
		logic [31:0]             w, a, b, v, t;
		logic [31:0]             imm_i, imm_b, imm_j, pc_ext, pc4_ext;
		logic [`RV_PC_WIDTH-1:0] pc4;
		logic                    wr, take;
		w       = prog[pc[`RV_PC_WIDTH-1:2]];
		a       = ref_regs[w[19:15]];
		b       = ref_regs[w[24:20]];
		imm_i   = {{20{w[31]}}, w[31:20]};
		imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		pc4     = pc + `RV_PC_WIDTH'd4;
		pc_ext  = {{(32-`RV_PC_WIDTH){1'b0}}, pc};
		pc4_ext = {{(32-`RV_PC_WIDTH){1'b0}}, pc4};
		next_pc = pc4;
		v       = '0;
		wr      = 1'b0;
		take    = 1'b0;
		case (w[6:0])
			opc_reg, opc_imm: begin
				if (w[6:0] == opc_imm)
					b = imm_i;
				wr = 1'b1;
				case (w[14:12])
					3'b000:  v = (w[6:0] == opc_reg && w[30]) ? a - b : a + b;
					3'b001:  v = a << b[4:0];
					3'b010:  v = {31'b0, $signed(a) < $signed(b)};
					3'b011:  v = {31'b0, a < b};
					3'b100:  v = a ^ b;
					3'b101: begin
						if (w[30])
							v = $signed(a) >>> b[4:0]; // sra / srai
						else
							v = a >> b[4:0];
					end
					3'b110:  v = a | b;
					default: v = a & b;
				endcase
			end
			opc_lui: begin
				wr = 1'b1;
				v  = {w[31:12], 12'b0};
			end
			opc_auipc: begin
				wr = 1'b1;
				v  = pc_ext + {w[31:12], 12'b0};
			end
			opc_jal: begin
				wr      = 1'b1;
				v       = pc4_ext;
				next_pc = pc + imm_j[`RV_PC_WIDTH-1:0];
			end
			opc_jalr: begin
				wr      = 1'b1;
				v       = pc4_ext;
				t       = a + imm_i;
				next_pc = {t[`RV_PC_WIDTH-1:1], 1'b0};
			end
			opc_branch: begin
				case (w[14:12])
					3'b000:  take = (a == b);
					3'b001:  take = (a != b);
					3'b100:  take = ($signed(a) < $signed(b));
					3'b101:  take = ($signed(a) >= $signed(b));
					3'b110:  take = (a < b);
					3'b111:  take = (a >= b);
					default: take = 1'b0;
				endcase
				if (take)
					next_pc = pc + imm_b[`RV_PC_WIDTH-1:0];
			end
			default: ; // anything else retires without effect
		endcase
		r.valid = 1'b1;
		r.pc    = pc;
		r.rd    = w[11:7];
		r.wb_en = wr && (w[11:7] != 5'd0); // x0 never written
		r.value = v;
		if (r.wb_en)
			ref_regs[w[11:7]] = v;
		return r;
	endfunction

	// runs the model from pc 0 with clean registers until the end word
	task automatic build_expected(output int steps);
		logic [`RV_PC_WIDTH-1:0] pc, npc;
		steps = 0;
		pc    = '0;
		exp_q.delete();
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		while (prog[pc[`RV_PC_WIDTH-1:2]] != `RV_END_WORD && steps < 200) begin
			exp_q.push_back(model_step(pc, npc));
			pc = npc;
			steps++;
		end
	endtask

	task automatic compare_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t want);
		checked++;
		if (got.pc !== want.pc || got.rd !== want.rd || got.wb_en !== want.wb_en ||
		    (want.wb_en && got.value !== want.value)) begin
			mismatch_errors++;
			$display("MISMATCH at %0t: retire pc %h rd %0d wb_en %b value %h, %s %h %0d %b %h",
			         $time, got.pc, got.rd, got.wb_en, got.value, "expected",
			         want.pc, want.rd, want.wb_en, want.value);
		end
	endtask

	task automatic check_halt(input logic got, input logic want, input string what);
		if (got !== want) begin
			mismatch_errors++;
			$display("MISMATCH at %0t: %s, halted %b expected %b", $time, what, got, want);
		end
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		if (retire.valid !== 1'b0) begin
			mismatch_errors++;
			$display("MISMATCH at %0t: retire.valid %b while in reset", $time, retire.valid);
		end
		check_halt(halted, 1'b0, "halted while in reset");
	endtask

	task automatic emit_word(input logic [31:0] w);
		prog[pc_idx] = w;
		pc_idx++;
	endtask

	task automatic clear_prog();
		for (int i = 0; i < `RV_IMEM_DEPTH; i++)
			prog[i] = `RV_END_WORD; // every unused word ends the code
		pc_idx = 0;
	endtask

	// lui + addi, upper part rounded for the signed low half
	task automatic emit_li(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800;
		emit_word(enc_u(opc_lui, hi[31:12], rd));
		emit_word(enc_i(opc_imm, v[11:0], rd, 3'b000, rd));
	endtask

	function automatic logic [31:0] rand_alu();
		logic [31:0] r, imm_r;
		logic [4:0]  rd, rs1, rs2;
		logic [2:0]  f3;
		logic [1:0]  kind;
		logic        alt;
		r     = $random(seed);
		imm_r = $random(seed);
		f3    = r[2:0];
		rd    = {2'b0, r[5:3]}; // x0..x7, x0 included on purpose
		rs1   = {2'b0, r[8:6]};
		rs2   = {2'b0, r[11:9]};
		alt   = r[17];
		kind  = r[19:18];
		if (kind == 2'd0)
			return enc_u(opc_lui, imm_r[19:0], rd);
		if (kind == 2'd1)
			return enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
			             rs2, rs1, f3, rd);
		if (f3 == 3'b001)
			return enc_i(opc_imm, {7'h00, r[16:12]}, rs1, f3, rd); // slli
		if (f3 == 3'b101)
			return enc_i(opc_imm, {alt ? 7'h20 : 7'h00, r[16:12]}, rs1, f3, rd);
		return enc_i(opc_imm, imm_r[11:0], rs1, f3, rd);
	endfunction

	task automatic gen_straight(input int n);
		clear_prog();
		for (int i = 1; i < 8; i++)
			emit_li(5'(i), $random(seed)); // seed x1..x7
		repeat (n)
			emit_word(rand_alu());
	endtask

	task automatic gen_jumps();
		clear_prog();
		emit_word(enc_u(opc_lui, 20'h12345, 5'd1));
		emit_word(enc_u(opc_auipc, 20'h00001, 5'd2));
		emit_word(enc_j(5'd3, 21'd12));                       // 8 -> 20
		emit_word(enc_i(opc_imm, 12'd1, 5'd0, 3'b000, 5'd4)); // squashed
		emit_word(enc_i(opc_imm, 12'd2, 5'd0, 3'b000, 5'd4));
		emit_word(enc_i(opc_imm, 12'd41, 5'd0, 3'b000, 5'd5));
		emit_word(enc_i(opc_jalr, 12'd0, 5'd5, 3'b000, 5'd6)); // 41 -> 40, bit 0 cleared
		emit_word(enc_i(opc_imm, 12'd3, 5'd0, 3'b000, 5'd7));
		emit_word(enc_i(opc_imm, 12'd4, 5'd0, 3'b000, 5'd7));
		emit_word(enc_i(opc_imm, 12'd5, 5'd0, 3'b000, 5'd7));
		emit_word(enc_j(5'd0, 21'd8));                        // link to x0
		emit_word(enc_i(opc_imm, 12'd6, 5'd0, 3'b000, 5'd8));
		emit_word(enc_i(opc_imm, 12'd64, 5'd0, 3'b000, 5'd10));
		emit_word(enc_i(opc_jalr, 12'hffc, 5'd10, 3'b000, 5'd11)); // 64-4 -> 60
		emit_word(enc_i(opc_imm, 12'd7, 5'd0, 3'b000, 5'd12));
		emit_word(enc_r(7'h00, 5'd6, 5'd3, 3'b000, 5'd13));
		emit_word(enc_u(opc_auipc, 20'hfffff, 5'd15));
	endtask

	// six branches on x1, x2; each taken one skips its counter increment
	task automatic gen_branches(input logic [31:0] a, input logic [31:0] b);
		logic [2:0] conds [6];
		conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		clear_prog();
		emit_li(5'd1, a);
		emit_li(5'd2, b);
		foreach (conds[i]) begin
			emit_word(enc_b(conds[i], 5'd1, 5'd2, 13'd8));
			emit_word(enc_i(opc_imm, 12'd1, 5'd3, 3'b000, 5'd3));
		end
	endtask

	task automatic gen_end_skip();
		clear_prog();
		prog[0] = enc_i(opc_imm, 12'd7, 5'd0, 3'b000, 5'd1);
		prog[1] = enc_b(3'b000, 5'd0, 5'd0, 13'd8); // over the end word at 8
		prog[3] = enc_i(opc_imm, 12'd1, 5'd1, 3'b000, 5'd2);
		prog[4] = enc_j(5'd0, 21'd8);               // over the end word at 20
		prog[6] = enc_i(opc_imm, 12'd9, 5'd2, 3'b000, 5'd3);
		prog[7] = enc_b(3'b001, 5'd0, 5'd0, 13'd8); // never taken, falls into the end
	endtask

	task automatic load_program();
		@(posedge clk);
		#5;
		reset = 1'b1;
		for (int i = 0; i < `RV_IMEM_DEPTH; i++) begin
			prog_we   = 1'b1;
			prog_addr = `RV_IMEM_ADDR_WIDTH'(i);
			prog_data = prog[i];
			@(posedge clk);
			#5;
		end
		prog_we = 1'b0;
		check_reset_state();
		@(posedge clk);
		#5;
		reset = 1'b0;
	endtask

	task automatic run_program(input logic with_stall, input int reset_after);
		int steps;
		build_expected(steps);
		budget = budget + `RV_IMEM_DEPTH + 20 + steps * 4 * ((reset_after > 0) ? 2 : 1);
		stall_en = with_stall; // stall is ignored while reset holds the core
		load_program();
		checking = 1'b1;
		if (reset_after > 0) begin
			repeat (reset_after) @(posedge clk);
			#5;
			reset    = 1'b1; // mid-run restart
			checking = 1'b0;
			check_reset_state();
			build_expected(steps);
			repeat (2) @(posedge clk);
			#5;
			reset    = 1'b0;
			checking = 1'b1;
		end
		wait (halted === 1'b1);
		stall_en = 1'b0;
		repeat (4) begin
			@(posedge clk);
			#5;
			check_halt(halted, 1'b1, "halted dropped after end of code");
		end
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("error at %0t: %0d expected retires never appeared", $time, exp_q.size());
		end
		checking = 1'b0;
	endtask

	// random stall level, changed just after the edge
	always @(posedge clk) begin
		#5;
		if (stall_en)
			stall = ($random(seed) & 3) == 0;
		else
			stall = 1'b0;
	end

	// outputs sampled mid-cycle where they are stable
	always @(negedge clk) begin
		if (checking && !reset) begin
			if (retire.valid === 1'b1) begin
				if (stalled_last) begin
					other_errors++;
					$display("error at %0t: retire in the cycle after a stall", $time);
				end
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("error at %0t: unexpected retire at pc %h", $time, retire.pc);
				end else begin
					compare_retire(retire, exp_q.pop_front());
				end
			end
			if (halted && !halted_last && exp_q.size() != 0) begin
				other_errors++;
				$display("error at %0t: halted with %0d retires outstanding", $time, exp_q.size());
			end
		end
		stalled_last = stall;
		halted_last  = halted;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > budget) begin
			$display("timeout: the run did not finish within %0d cycles", budget);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		repeat (3) begin
			gen_straight(24); // alu mix with shifts, slt and x0 targets
			run_program(1'b0, 0);
		end
		gen_jumps();
		run_program(1'b0, 0);
		gen_branches(32'h0000_0000, 32'h0000_0000);
		run_program(1'b0, 0);
		gen_branches(32'h8000_0000, 32'h7fff_ffff); // signed and unsigned disagree
		run_program(1'b0, 0);
		gen_branches(32'h7fff_ffff, 32'h8000_0000);
		run_program(1'b0, 0);
		gen_branches(32'hffff_ffff, 32'h0000_0001);
		run_program(1'b0, 0);
		gen_branches(32'h0000_0001, 32'hffff_ffff);
		run_program(1'b0, 0);
		gen_branches(32'hffff_ffff, 32'hffff_ffff);
		run_program(1'b0, 0);
		repeat (3) begin
			gen_branches($random(seed), $random(seed));
			run_program(1'b0, 0);
		end
		gen_straight(24);
		run_program(1'b1, 0); // stall pulses
		gen_end_skip();
		run_program(1'b0, 0);
		gen_branches(32'h0000_0000, 32'h0000_0001);
		run_program(1'b0, 9); // reset once x3 holds a count, restart reads it as zero
		@(posedge clk);
		$display("summary: %0d mismatches, %0d other errors, %0d retires checked",
		         mismatch_errors, other_errors, checked);
		if (mismatch_errors + other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: verif/tb_clock.sv
/* free-running testbench clock, 100 ns period
   instantiated once by the core testbench */

`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #50 clk = ~clk; // half period

endmodule

// File: hdl/rv_core.sv
/* top level of the single-issue RV32I core: fetch, decode, execute
   and result around the instruction memory and register file */

`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           stall,
	input  logic                           prog_we,   // program load, reset only
	input  logic [`RV_IMEM_ADDR_WIDTH-1:0] prog_addr,
	input  logic [31:0]                    prog_data,
	output rv_pkg::retire_t                retire,
	output logic                           halted
);

	logic [`RV_PC_WIDTH-1:0]       inst_addr;
	rv_pkg::inst_u                 inst_word;
	rv_pkg::fetch_t                fetch;
	rv_pkg::dec_t                  dec;
	rv_pkg::redirect_t             redirect;
	rv_pkg::retire_t               exec_result;
	logic [`RV_REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr;
	logic [`RV_XLEN-1:0]           rs1_data, rs2_data;
	logic                          rf_we;
	logic [`RV_REG_ADDR_WIDTH-1:0] rf_waddr;
	logic [`RV_XLEN-1:0]           rf_wdata;

	inst_mem inst_mem_i (
		.clk(clk), .addr(inst_addr), .rdata(inst_word),
		.we(prog_we), .waddr(prog_addr), .wdata(prog_data)
	);

	fetch_unit fetch_unit_i (
		.clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
		.inst_addr(inst_addr), .inst_word(inst_word), .fetch(fetch), .halted(halted)
	);

	reg_file reg_file_i (
		.clk(clk), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	decode_unit decode_unit_i (
		.fetch(fetch), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .dec(dec)
	);

	execute_unit execute_unit_i (
		.dec(dec), .redirect(redirect), .result(exec_result)
	);

	result_unit result_unit_i (
		.clk(clk), .reset(reset), .result(exec_result),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata), .retire(retire)
	);

endmodule

// File: hdl/result_unit.sv
/* register file write from the execute result, and the retire report
   registered one cycle later */

`timescale 1ns/1ps
`include "rv_params.svh"

module result_unit (
	input  logic                          clk,
	input  logic                          reset,
	input  rv_pkg::retire_t               result,
	output logic                          we,
	output logic [`RV_REG_ADDR_WIDTH-1:0] waddr,
	output logic [`RV_XLEN-1:0]           wdata,
	output rv_pkg::retire_t               retire
);

	logic            valid_q;
	rv_pkg::retire_t payload_q;
	logic            wr_rd;     // architectural write, x0 excluded

	assign wr_rd = result.wb_en && (result.rd != '0);
	assign we    = result.valid && wr_rd;
	assign waddr = result.rd;
	assign wdata = result.value;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= result.valid; // low under stall or bubble
		end
	end

	always_ff @(posedge clk) begin
		payload_q       <= result;
		payload_q.wb_en <= wr_rd; // report what really landed
	end

	always_comb begin
		retire       = payload_q;
		retire.valid = valid_q;
	end

endmodule

// File: hdl/execute_unit.sv
/* alu, branch compare and target calculation; drives the redirect
   to fetch and the combinational result toward the write stage */

`timescale 1ns/1ps
`include "rv_params.svh"

module execute_unit (
	input  rv_pkg::dec_t      dec,
	output rv_pkg::redirect_t redirect,
	output rv_pkg::retire_t   result
);

	logic [`RV_XLEN-1:0]     alu_res;
	logic [4:0]              shamt;
	logic                    taken;
	logic [`RV_PC_WIDTH-1:0] pc_plus_4;
	logic [`RV_PC_WIDTH-1:0] pc_rel; // pc+imm, shared by sb and uj

	assign shamt     = dec.opb[4:0];
	assign pc_plus_4 = dec.pc + `RV_PC_WIDTH'd4;
	assign pc_rel    = dec.pc + dec.imm[`RV_PC_WIDTH-1:0];

	always_comb begin
		case (dec.alu_op)
			rv_pkg::alu_add:    alu_res = dec.opa + dec.opb;
			rv_pkg::alu_sub:    alu_res = dec.opa - dec.opb;
			rv_pkg::alu_sll:    alu_res = dec.opa << shamt;
			rv_pkg::alu_slt:    alu_res = {31'b0, $signed(dec.opa) < $signed(dec.opb)};
			rv_pkg::alu_sltu:   alu_res = {31'b0, dec.opa < dec.opb};
			rv_pkg::alu_xor:    alu_res = dec.opa ^ dec.opb;
			rv_pkg::alu_srl:    alu_res = dec.opa >> shamt;
			rv_pkg::alu_sra:    alu_res = $unsigned($signed(dec.opa) >>> shamt);
			rv_pkg::alu_or:     alu_res = dec.opa | dec.opb;
			rv_pkg::alu_and:    alu_res = dec.opa & dec.opb;
			rv_pkg::alu_pass_b: alu_res = dec.opb;   // lui
			default:            alu_res = dec.opa + dec.opb;
		endcase
	end

	// rs1 sits in opa for branches, rs2 travels separately
	always_comb begin
		case (dec.br_cond)
			rv_pkg::br_eq:  taken = (dec.opa == dec.rs2_val);
			rv_pkg::br_ne:  taken = (dec.opa != dec.rs2_val);
			rv_pkg::br_lt:  taken = ($signed(dec.opa) < $signed(dec.rs2_val));
			rv_pkg::br_ge:  taken = ($signed(dec.opa) >= $signed(dec.rs2_val));
			rv_pkg::br_ltu: taken = (dec.opa < dec.rs2_val);
			rv_pkg::br_geu: taken = (dec.opa >= dec.rs2_val);
			default:        taken = 1'b0;
		endcase
	end

	always_comb begin
		redirect.sel    = rv_pkg::pc_plus_4_t; // invalid or not taken
		redirect.target = pc_plus_4;
		if (dec.valid) begin
			if (dec.jump == rv_pkg::uj) begin
				redirect.sel    = rv_pkg::uj;
				redirect.target = pc_rel;
			end else if (dec.jump == rv_pkg::jalr) begin
				redirect.sel    = rv_pkg::jalr;
				redirect.target = {alu_res[`RV_PC_WIDTH-1:1], 1'b0}; // bit 0 cleared
			end else if (taken) begin
				redirect.sel    = rv_pkg::sb;
				redirect.target = pc_rel;
			end
		end
	end

	always_comb begin
		result.valid = dec.valid;
		result.pc    = dec.pc;
		result.rd    = dec.rd;
		result.wb_en = dec.wb_en;
		result.value = dec.link ? {{(`RV_XLEN-`RV_PC_WIDTH){1'b0}}, pc_plus_4} : alu_res;
	end

endmodule

// File: hdl/decode_unit.sv
/* decode of the fetched word through the format union: immediate,
   alu operation, operand choice and control flags, all combinational */

`timescale 1ns/1ps
`include "rv_params.svh"

module decode_unit (
	input  rv_pkg::fetch_t                fetch,
	output logic [`RV_REG_ADDR_WIDTH-1:0] rs1_addr,
	output logic [`RV_REG_ADDR_WIDTH-1:0] rs2_addr,
	input  logic [`RV_XLEN-1:0]           rs1_data,
	input  logic [`RV_XLEN-1:0]           rs2_data,
	output rv_pkg::dec_t                  dec
);

	rv_pkg::inst_u       inst;
	logic [`RV_XLEN-1:0] imm_i, imm_b, imm_u, imm_j;
	logic [`RV_XLEN-1:0] pc_ext;

	// funct3 to alu op, alt picks sub/sra
	function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] funct3,
	                                            input logic alt, input logic is_reg);
		case (funct3)
			3'b000:  alu_sel = (is_reg && alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001:  alu_sel = rv_pkg::alu_sll;
			3'b010:  alu_sel = rv_pkg::alu_slt;
			3'b011:  alu_sel = rv_pkg::alu_sltu;
			3'b100:  alu_sel = rv_pkg::alu_xor;
			3'b101:  alu_sel = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110:  alu_sel = rv_pkg::alu_or;
			default: alu_sel = rv_pkg::alu_and;
		endcase
	endfunction

	assign inst.raw = fetch.valid ? fetch.inst.raw : `RV_NOP; // bubble decodes as nop
	assign rs1_addr = inst.r.rs1; // same position in every format
	assign rs2_addr = inst.r.rs2;
	assign pc_ext   = {{(`RV_XLEN-`RV_PC_WIDTH){1'b0}}, fetch.pc};

	// sign-extended immediates per format
	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign imm_b = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
	assign imm_u = {inst.u.imm31_12, 12'b0};
	assign imm_j = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
	                inst.j.imm10_1, 1'b0};

	always_comb begin
		dec         = '0;
		dec.valid   = fetch.valid;
		dec.pc      = fetch.pc;
		dec.alu_op  = rv_pkg::alu_add;
		dec.opa     = rs1_data;
		dec.opb     = imm_i;
		dec.rs2_val = rs2_data;
		dec.imm     = imm_i;
		dec.rd      = inst.r.rd;
		dec.wb_en   = 1'b0;
		dec.link    = 1'b0;
		dec.br_cond = rv_pkg::br_none;
		dec.jump    = rv_pkg::pc_plus_4_t;
		case (inst.raw[6:0])
			rv_pkg::op_reg: begin
				dec.opb    = rs2_data;
				dec.alu_op = alu_sel(inst.r.funct3, inst.r.funct7[5], 1'b1);
				dec.wb_en  = 1'b1;
			end
			rv_pkg::op_imm: begin
				dec.alu_op = alu_sel(inst.i.funct3, inst.i.imm[10], 1'b0); // imm[10] marks srai
				dec.wb_en  = 1'b1;
			end
			rv_pkg::op_lui: begin
				dec.alu_op = rv_pkg::alu_pass_b;
				dec.opb    = imm_u;
				dec.imm    = imm_u;
				dec.wb_en  = 1'b1;
			end
			rv_pkg::op_auipc: begin
				dec.opa    = pc_ext;
				dec.opb    = imm_u;
				dec.imm    = imm_u;
				dec.wb_en  = 1'b1;
			end
			rv_pkg::op_jal: begin
				dec.opa    = pc_ext;
				dec.opb    = imm_j;
				dec.imm    = imm_j;
				dec.link   = 1'b1;
				dec.wb_en  = 1'b1;
				dec.jump   = rv_pkg::uj;
			end
			rv_pkg::op_jalr: begin
				dec.link   = 1'b1; // rs1+imm formed by the alu
				dec.wb_en  = 1'b1;
				dec.jump   = rv_pkg::jalr;
			end
			rv_pkg::op_branch: begin
				dec.opb    = imm_b;
				dec.imm    = imm_b;
				case (inst.b.funct3)
					3'b000:  dec.br_cond = rv_pkg::br_eq;
					3'b001:  dec.br_cond = rv_pkg::br_ne;
					3'b100:  dec.br_cond = rv_pkg::br_lt;
					3'b101:  dec.br_cond = rv_pkg::br_ge;
					3'b110:  dec.br_cond = rv_pkg::br_ltu;
					3'b111:  dec.br_cond = rv_pkg::br_geu;
					default: dec.br_cond = rv_pkg::br_none;
				endcase
			end
			default: ; // unknown opcode retires as a nop
		endcase
	end

endmodule

// File: hdl/reg_file.sv
/* integer register file, two combinational read ports and one write port
   x0 is hardwired to zero */

`timescale 1ns/1ps
`include "rv_params.svh"

module reg_file (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`RV_REG_ADDR_WIDTH-1:0] rs1_addr,
	input  logic [`RV_REG_ADDR_WIDTH-1:0] rs2_addr,
	output logic [`RV_XLEN-1:0]           rs1_data,
	output logic [`RV_XLEN-1:0]           rs2_data,
	input  logic                          we,
	input  logic [`RV_REG_ADDR_WIDTH-1:0] waddr,
	input  logic [`RV_XLEN-1:0]           wdata
);

	logic [`RV_XLEN-1:0] regs [1:31]; // x1..x31 only

	always_comb begin
		rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
		rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int r = 1; r < 32; r++) begin
				regs[r] <= '0; // architectural state starts clean
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

// File: hdl/fetch_unit.sv
/* program counter and fetch register; follows the redirect from execute,
   squashes the wrong-path word and stops at the all-zero end marker */

`timescale 1ns/1ps
`include "rv_params.svh"

module fetch_unit (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stall,
	input  rv_pkg::redirect_t       redirect,
	output logic [`RV_PC_WIDTH-1:0] inst_addr,
	input  rv_pkg::inst_u           inst_word,
	output rv_pkg::fetch_t          fetch,
	output logic                    halted
);

	logic [`RV_PC_WIDTH-1:0] pc_q;         // address of the word being read
	logic                    fetch_valid_q;
	logic [`RV_PC_WIDTH-1:0] fetch_pc_q;
	rv_pkg::inst_u           fetch_inst_q;
	logic                    halted_q;
	logic                    take_redirect;
	logic                    end_hit;

	assign take_redirect = (redirect.sel != rv_pkg::pc_plus_4_t);
	assign end_hit       = (inst_word.raw == `RV_END_WORD);
	assign inst_addr     = pc_q;
	assign halted        = halted_q;

	always_comb begin
		fetch.valid = fetch_valid_q & ~stall; // stall hides the held word
		fetch.pc    = fetch_pc_q;
		fetch.inst  = fetch_inst_q;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc_q          <= '0;
			fetch_valid_q <= 1'b0;
			halted_q      <= 1'b0;
		end else if (!stall && !halted_q) begin
			if (take_redirect) begin
				pc_q          <= redirect.target; // sb, uj or jalr target
				fetch_valid_q <= 1'b0;            // drop the wrong-path word
			end else if (end_hit) begin
				halted_q      <= 1'b1;            // freeze until reset
				fetch_valid_q <= 1'b0;
			end else begin
				pc_q          <= pc_q + `RV_PC_WIDTH'd4;
				fetch_valid_q <= 1'b1;
			end
		end
	end

	// payload only, qualified by fetch_valid_q
	always_ff @(posedge clk) begin
		if (!stall) begin
			fetch_pc_q   <= pc_q;
			fetch_inst_q <= inst_word;
		end
	end

endmodule

// File: hdl/inst_mem.sv
/* instruction memory, combinational read at the pc word index
   and a clocked load port used while the core sits in reset */

`timescale 1ns/1ps
`include "rv_params.svh"

module inst_mem (
	input  logic                           clk,
	input  logic [`RV_PC_WIDTH-1:0]        addr,  // byte address from fetch
	output rv_pkg::inst_u                  rdata,
	input  logic                           we,
	input  logic [`RV_IMEM_ADDR_WIDTH-1:0] waddr, // word index
	input  logic [31:0]                    wdata
);

	logic [31:0] mem [0:`RV_IMEM_DEPTH-1]; // no reset, loaded from outside
	logic [`RV_IMEM_ADDR_WIDTH-1:0] word_idx;

	assign word_idx  = addr[`RV_PC_WIDTH-1:2]; // low two bits always zero
	assign rdata.raw = mem[word_idx];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

endmodule

// File: hdl/rv_pkg.sv
/* shared types of the RV32I core: control enums, instruction formats
   and the structs passed between the pipeline units */

`include "rv_params.svh"

package rv_pkg;

	// how fetch forms the next pc
	typedef enum logic [1:0] {pc_plus_4_t, sb, uj, jalr} next_pc_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
		alu_srl, alu_sra, alu_or, alu_and, alu_pass_b // pass_b for lui
	} alu_op_t;

	typedef enum logic [2:0] {br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu} br_cond_t;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
		logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
		logic [4:0] rd;   logic [6:0] opcode;
	} i_fmt_t;

	// branch immediate is scattered, bit 0 implied zero
	typedef struct packed {
		logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
		logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12; logic [4:0] rd; logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
		logic [4:0] rd; logic [6:0] opcode;
	} j_fmt_t;

	// one word, six views
	typedef union packed {
		logic [31:0] raw;
		r_fmt_t      r;
		i_fmt_t      i;
		b_fmt_t      b;
		u_fmt_t      u;
		j_fmt_t      j;
	} inst_u;

	typedef struct packed {
		logic                    valid;
		logic [`RV_PC_WIDTH-1:0] pc;
		inst_u                   inst;
	} fetch_t;

	typedef struct packed {
		logic                          valid;
		logic [`RV_PC_WIDTH-1:0]       pc;
		alu_op_t                       alu_op;
		logic [`RV_XLEN-1:0]           opa;     // rs1 or pc
		logic [`RV_XLEN-1:0]           opb;     // rs2 or imm
		logic [`RV_XLEN-1:0]           rs2_val; // branch compare
		logic [`RV_XLEN-1:0]           imm;
		logic [`RV_REG_ADDR_WIDTH-1:0] rd;
		logic                          wb_en;
		logic                          link;    // write pc+4
		br_cond_t                      br_cond;
		next_pc_t                      jump;
	} dec_t;

	typedef struct packed {
		next_pc_t                sel;
		logic [`RV_PC_WIDTH-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic                          valid;
		logic [`RV_PC_WIDTH-1:0]       pc;
		logic [`RV_REG_ADDR_WIDTH-1:0] rd;
		logic                          wb_en;
		logic [`RV_XLEN-1:0]           value;
	} retire_t;

endpackage

// File: include/rv_params.svh
/* core-wide width and memory constants for the RV32I core
   included by the package and by every module that sizes a port */

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_XLEN            32             // data path width
`define RV_PC_WIDTH        8              // byte address, covers 64 words
`define RV_IMEM_DEPTH      64             // instruction words
`define RV_IMEM_ADDR_WIDTH 6              // word index into instruction memory
`define RV_REG_ADDR_WIDTH  5              // x0..x31

`define RV_NOP      32'h0000_0013         // addi x0,x0,0
`define RV_END_WORD 32'h0000_0000         // end of code marker

`endif
